/* tftController.sv */
// TFT bring-up and pixel stream controller
module tftController import tftPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  delayT     resetDelay,
	input  delayT     powerUpDelay,
	input  delayT     settleDelay,
	output initIdxT   romIdx,
	input  spiWordT   romWord,
	output logic      wordValid,
	output spiWordT   wordData,
	input  logic      wordReady,
	input  logic      pixelValid,
	input  pixelT     pixelData,
	output logic      pixelReady,
	output logic      tftReset,
	output ctrlStateT state
);

	delayT      delayCnt;   // down counter for all delays
	logic       romWait;    // waiting on the registered rom read
	logic       initDone;   // second settle leads to stream
	logic       lowPending; // low byte of last pixel not yet queued
	logic [7:0] lowByte;
	logic       wordTaken;

	assign wordTaken = wordValid && wordReady;

	// only take a pixel once both bytes of the previous one are out
	assign pixelReady = (state == stream) && !wordValid && !lowPending;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state      <= idle;
			tftReset   <= 1'b1;
			wordValid  <= 1'b0;
			delayCnt   <= '0;
			romIdx     <= '0;
			romWait    <= 1'b0;
			initDone   <= 1'b0;
			lowPending <= 1'b0;
		end else begin
			case (state)
				idle: begin
					state    <= holdReset;
					tftReset <= 1'b0;
					delayCnt <= resetDelay;
				end
				holdReset: begin // low for resetDelay+1 cycles
					if (delayCnt == '0) begin
						tftReset <= 1'b1;
						delayCnt <= powerUpDelay;
						state    <= waitPowerUp;
					end else
						delayCnt <= delayCnt - delayT'(1);
				end
				waitPowerUp: begin
					if (delayCnt == '0) begin
						wordValid <= 1'b1; // queue sleep out
						wordData  <= sleepOutCmd;
						initDone  <= 1'b0;
						state     <= settle;
					end else
						delayCnt <= delayCnt - delayT'(1);
				end
				settle: begin
					// count starts once the serializer is idle again
					if (wordValid) begin
						if (wordTaken)
							wordValid <= 1'b0;
						delayCnt <= settleDelay;
					end else if (!wordReady)
						delayCnt <= settleDelay; // transfer still on the wire
					else if (delayCnt != '0)
						delayCnt <= delayCnt - delayT'(1);
					else if (initDone)
						state <= stream;
					else begin
						romIdx  <= '0;
						romWait <= 1'b1;
						state   <= sendInit;
					end
				end
				sendInit: begin
					if (wordValid) begin
						if (wordTaken) begin
							wordValid <= 1'b0;
							if (romIdx == initIdxT'(initSeqLen - 1)) begin
								initDone <= 1'b1;
								state    <= settle;
							end else begin
								romIdx  <= romIdx + initIdxT'(1);
								romWait <= 1'b1;
							end
						end
					end else if (romWait)
						romWait <= 1'b0; // rom output updates this edge
					else begin
						wordValid <= 1'b1;
						wordData  <= romWord;
					end
				end
				stream: begin
					if (wordValid) begin
						if (wordTaken)
							wordValid <= 1'b0;
					end else if (lowPending) begin
						wordValid  <= 1'b1;
						wordData   <= {1'b1, lowByte}; // low byte second
						lowPending <= 1'b0;
					end else if (pixelValid && pixelReady) begin
						wordValid  <= 1'b1;
						wordData   <= {1'b1, pixelData[15:8]}; // high byte first
						lowByte    <= pixelData[7:0];
						lowPending <= 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// pixels only accepted while streaming
	assert property (@(posedge clk) disable iff (!rstN)
		pixelReady |-> state == stream)
		else $error("pixelReady outside stream");

	// word held until the serializer takes it
	assert property (@(posedge clk) disable iff (!rstN)
		(wordValid && !wordReady) |=> (wordValid && $stable(wordData)))
		else $error("word changed before accepted");

endmodule

/* tftDisplay.f */
tftPkg.sv
tftTimingRegs.sv
tftInitRom.sv
tftSpiSerializer.sv
tftController.sv
tftDisplay.sv
tftDisplayTb.sv

/* tftDisplay.sv */
// TFT display top level
module tftDisplay import tftPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  logic      regWrite,
	input  regAddrT   regAddr,
	input  delayT     regWData,
	output delayT     regRData,
	input  logic      pixelValid,
	input  pixelT     pixelData,
	output logic      pixelReady,
	output logic      tftSck,
	output logic      tftSdi,
	output logic      tftDc,
	output logic      tftCs,
	output logic      tftReset,
	output ctrlStateT stateOut
);

	delayT   resetDelay;
	delayT   powerUpDelay;
	delayT   settleDelay;
	initIdxT romIdx;
	spiWordT romWord;
	logic    wordValid;
	spiWordT wordData;
	logic    wordReady;

	// delay lengths, writable from outside
	tftTimingRegs u_regs (
		.clk          (clk),
		.rstN         (rstN),
		.regWrite     (regWrite),
		.regAddr      (regAddr),
		.regWData     (regWData),
		.regRData     (regRData),
		.resetDelay   (resetDelay),
		.powerUpDelay (powerUpDelay),
		.settleDelay  (settleDelay)
	);

	tftInitRom u_rom (
		.clk  (clk),
		.idx  (romIdx),
		.word (romWord)
	);

	tftController u_ctrl (
		.clk          (clk),
		.rstN         (rstN),
		.resetDelay   (resetDelay),
		.powerUpDelay (powerUpDelay),
		.settleDelay  (settleDelay),
		.romIdx       (romIdx),
		.romWord      (romWord),
		.wordValid    (wordValid),
		.wordData     (wordData),
		.wordReady    (wordReady),
		.pixelValid   (pixelValid),
		.pixelData    (pixelData),
		.pixelReady   (pixelReady),
		.tftReset     (tftReset),
		.state        (stateOut)
	);

	// serial link to the panel
	tftSpiSerializer u_spi (
		.clk       (clk),
		.rstN      (rstN),
		.wordValid (wordValid),
		.wordData  (wordData),
		.wordReady (wordReady),
		.tftSck    (tftSck),
		.tftSdi    (tftSdi),
		.tftDc     (tftDc),
		.tftCs     (tftCs)
	);

endmodule

/* tftDisplayTb.sv */
// TFT display testbench
module tftDisplayTb;

	localparam int resetDefault = 10 * 12; // 10 us at 12 MHz, pulse starts before any write
	localparam logic [2:0] streamState = 3'd5; // sixth controller state

	logic clk = 1'b0;
	logic rstN, regWrite, pixelValid;
	logic [1:0] regAddr;
	logic [23:0] regWData, regRData;
	logic [15:0] pixelData;
	logic pixelReady, tftSck, tftSdi, tftDc, tftCs, tftReset;
	logic [2:0] stateOut;

	logic [23:0] pat [64]; // patterns file contents
	logic [31:0] lfsr = 32'h4a7a_aba0;
	int cycle = 0;
	int limit, pixCnt, nWords;
	int wordIdx = 0;
	int frameLen, sckRises, lowCycles = 0, highRun = 0;
	logic [7:0] bits;
	logic frameDc;
	logic prevCs = 1'b1;
	logic prevSck = 1'b1;

	tftDisplay i_dut (.*);

	always #4 clk = ~clk;

	// galois lfsr, one bit per call
	function automatic logic nextBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h8020_0003;
		return out;
	endfunction

	task automatic failRun();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			failRun();
		end
	endtask

	always @(posedge clk) begin
		cycle++;
		if (cycle > limit) begin
			$display("timeout: serial output still incomplete after %0d cycles", cycle);
			failRun();
		end
	end

	// serial decoder, sampled on falling clk where outputs are settled
	always @(negedge clk) begin
		if (!tftReset)
			lowCycles++;
		if (prevCs && !tftCs) begin // frame start
			checkValue("tftReset", tftReset, 1);
			checkValue("stateOut is stream", stateOut == streamState, wordIdx >= 13); // pixels only
			if (wordIdx == 1 || wordIdx == 13) // after sleep-out, after last init word
				checkValue("settle gap above settleDelay", highRun > pat[2], 1);
			frameLen = 0;
			sckRises = 0;
			frameDc = tftDc;
		end
		if (!tftCs) begin
			frameLen++;
			checkValue("tftDc", tftDc, frameDc);
			if (!prevSck && tftSck) begin
				bits = {bits[6:0], tftSdi}; // msb first
				sckRises++;
			end
		end
		if (!prevCs && tftCs) begin // frame end
			checkValue("tftCs low cycles", frameLen, 16);
			checkValue("tftSck rises", sckRises, 8);
			if (wordIdx >= nWords) begin
				$display("serial word sent beyond the expected sequence");
				failRun();
			end
			checkValue("serial word", {frameDc, bits}, pat[4 + pixCnt + wordIdx]);
			wordIdx++;
			highRun = 0;
		end
		if (tftCs)
			highRun++;
		prevCs = tftCs;
		prevSck = tftSck;
	end

	initial begin
		int stall;
		$readmemh("tftPatterns.mem", pat);
		pixCnt = pat[3];
		nWords = 13 + 2 * pixCnt; // sleep-out, 12 init, two per pixel
		limit = 40 + resetDefault + pat[1] + 2 * (pat[2] + 8) + 17 * nWords + 3 * pixCnt + 200;
		rstN = 1'b0;
		regWrite = 1'b0;
		regAddr = '0;
		regWData = '0;
		pixelValid = 1'b0;
		pixelData = '0;
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		for (int a = 0; a < 3; a++) begin // short delays, before power-up is sampled
			@(negedge clk);
			regWrite = 1'b1;
			regAddr = a;
			regWData = pat[a];
		end
		@(negedge clk);
		regWrite = 1'b0;
		for (int a = 0; a < 4; a++) begin
			regAddr = a;
			@(negedge clk);
			checkValue("regRData", regRData, (a < 3) ? pat[a] : 0); // addr 3 reads zero
		end
		for (int p = 0; p < pixCnt; p++) begin
			while (!pixelReady) // previous pixel still going out
				@(negedge clk);
			stall = {nextBit(), nextBit()};
			repeat (stall) @(negedge clk); // ready high, valid held low
			pixelValid = 1'b1;
			pixelData = pat[4 + p][15:0];
			@(negedge clk); // taken on the edge in between
			pixelValid = 1'b0;
		end
		wait (wordIdx == nWords);
		repeat (40) @(negedge clk); // room for stray words
		checkValue("tftReset low cycles", lowCycles, resetDefault + 1);
		$display("All tests passed!");
		$finish;
	end

endmodule

/* tftInit.mem */
// init words: bit 8 is the dc flag (1 data), bits 7:0 the byte
03A
155
036
128
02A
100
100
101
13F
013
029
02C

/* tftInitRom.sv */
// Init sequence ROM
module tftInitRom import tftPkg::*; (
	input  logic    clk,
	input  initIdxT idx,
	output spiWordT word
);

	// table contents, one 9-bit word per entry
	spiWordT rom [initSeqLen];

	initial begin
		$readmemh("tftInit.mem", rom);
	end

	// registered read, word valid one cycle after idx
	always_ff @(posedge clk) begin
		word <= rom[idx];
	end

endmodule

/* tftPatterns.mem */
// delays: reset, power-up, settle; then pixel count and rgb565 pixels
// then expected serial words {dc, byte}: sleep-out, init table, two per pixel
000005
000014
000008
000003
00F800
0007E0
001234
000011
00003A
000155
000036
000128
00002A
000100
000100
000101
00013F
000013
000029
00002C
0001F8
000100
000107
0001E0
000112
000134

/* tftPkg.sv */
// TFT display shared definitions
package tftPkg;

	// basic widths
	typedef logic [8:0]  spiWordT; // [8] = dc flag (1 data), [7:0] = byte
	typedef logic [15:0] pixelT;   // rgb565
	typedef logic [23:0] delayT;   // delay length in clk cycles
	typedef logic [1:0]  regAddrT; // timing register address
	typedef logic [3:0]  initIdxT; // init table index

	// controller FSM
	typedef enum logic [2:0] {
		idle,        // just out of reset
		holdReset,   // panel reset line held low
		waitPowerUp, // panel powering up
		sendInit,    // walking the init table
		settle,      // settle delay after sleep-out and after init
		stream       // pixels forever
	} ctrlStateT;

	// init table
	localparam int initSeqLen = 12;

	// sleep out, command word
	localparam spiWordT sleepOutCmd = {1'b0, 8'h11};

	// reset defaults, nominal 12 MHz clock
	localparam int clkMhz = 12;
	localparam delayT resetDelayDefault   = delayT'(clkMhz * 10);     // 10 us
	localparam delayT powerUpDelayDefault = delayT'(clkMhz * 120000); // 120 ms
	localparam delayT settleDelayDefault  = delayT'(clkMhz * 10000);  // 10 ms

	// register map
	localparam regAddrT addrReset   = 2'd0;
	localparam regAddrT addrPowerUp = 2'd1;
	localparam regAddrT addrSettle  = 2'd2;

endpackage

/* tftSpiSerializer.sv */
// TFT serial word transmitter
module tftSpiSerializer import tftPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    wordValid,
	input  spiWordT wordData,
	output logic    wordReady,
	output logic    tftSck,
	output logic    tftSdi,
	output logic    tftDc,
	output logic    tftCs
);

	logic [7:0] shiftReg; // remaining bits, msb next
	logic [3:0] bitCnt;   // bits done, 8 means idle

	assign wordReady = bitCnt[3]; // idle exactly when counter parked at 8

	// tftSck doubles as the phase bit: low half then high half of each bit
	always_ff @(posedge clk) begin
		if (!rstN) begin
			bitCnt <= 4'd8;
			tftCs  <= 1'b1;
			tftSck <= 1'b1;
			tftSdi <= 1'b0;
			tftDc  <= 1'b0;
		end else if (wordReady) begin
			if (wordValid) begin // accept a word
				tftCs    <= 1'b0;
				tftSck   <= 1'b0;
				tftDc    <= wordData[8];  // held for the whole transfer
				tftSdi   <= wordData[7];  // msb first
				shiftReg <= {wordData[6:0], 1'b0};
				bitCnt   <= 4'd0;
			end
		end else if (!tftSck) begin
			tftSck <= 1'b1; // panel samples sdi here
		end else if (bitCnt == 4'd7) begin
			// last bit done, release cs, sck parks high
			tftCs  <= 1'b1;
			bitCnt <= 4'd8;
		end else begin
			tftSck   <= 1'b0;
			tftSdi   <= shiftReg[7];
			shiftReg <= {shiftReg[6:0], 1'b0};
			bitCnt   <= bitCnt + 4'd1;
		end
	end

	// no clock pulses outside a frame
	assert property (@(posedge clk) disable iff (!rstN)
		tftCs |-> tftSck)
		else $error("sck low while cs high");

	// dc frozen for the length of a transfer
	assert property (@(posedge clk) disable iff (!rstN)
		(!tftCs && !$past(tftCs)) |-> $stable(tftDc))
		else $error("dc changed during transfer");

	// frame is 16 cycles long, then cs high for at least a cycle
	assert property (@(posedge clk) disable iff (!rstN)
		$fell(tftCs) |-> (!tftCs [*16]) ##1 tftCs)
		else $error("cs low time not 16 cycles");

endmodule

/* tftTimingRegs.sv */
// TFT delay length registers
module tftTimingRegs import tftPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    regWrite,
	input  regAddrT regAddr,
	input  delayT   regWData,
	output delayT   regRData,
	output delayT   resetDelay,
	output delayT   powerUpDelay,
	output delayT   settleDelay
);

	// write port, takes effect next edge
	always_ff @(posedge clk) begin
		if (!rstN) begin
			resetDelay   <= resetDelayDefault;
			powerUpDelay <= powerUpDelayDefault;
			settleDelay  <= settleDelayDefault;
		end else if (regWrite) begin
			case (regAddr)
				addrReset:   resetDelay   <= regWData;
				addrPowerUp: powerUpDelay <= regWData;
				addrSettle:  settleDelay  <= regWData;
				default: ; // addr 3 unmapped, write dropped
			endcase
		end
	end

	// readback mux
	always_comb begin
		case (regAddr)
			addrReset:   regRData = resetDelay;
			addrPowerUp: regRData = powerUpDelay;
			addrSettle:  regRData = settleDelay;
			default:     regRData = '0; // unmapped reads zero
		endcase
	end

endmodule
